// File: source/mips_decode_defines.svh
`ifndef MIPS_DECODE_DEFINES_SVH
`define MIPS_DECODE_DEFINES_SVH

`define DATA_W 32                         // Datapath and PC width

// Primary opcodes, instruction bits 31:26
`define OP_SPECIAL 6'b000000              // R-type, JR and JALR share this opcode
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDI    6'b001000
`define OP_SLTI    6'b001010
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000              // Loads keep the access size in bits 1:0
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100              // Bit 2 marks the unsigned loads
`define OP_LHU     6'b100101
`define OP_SB      6'b101000              // Bit 3 marks a store
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// R-type function codes, instruction bits 5:0
`define FUNC_SLL   6'b000000
`define FUNC_SRL   6'b000010
`define FUNC_SRA   6'b000011
`define FUNC_SLLV  6'b000100
`define FUNC_SRLV  6'b000110
`define FUNC_SRAV  6'b000111
`define FUNC_JR    6'b001000
`define FUNC_JALR  6'b001001
`define FUNC_ADDU  6'b100001
`define FUNC_SUBU  6'b100011
`define FUNC_AND   6'b100100
`define FUNC_OR    6'b100101
`define FUNC_XOR   6'b100110
`define FUNC_NOR   6'b100111
`define FUNC_SLT   6'b101010

// Immediate arithmetic codes, the low three opcode bits zero padded
`define FUNC_ADDI  6'b000000
`define FUNC_SLTI  6'b000010
`define FUNC_ANDI  6'b000100
`define FUNC_ORI   6'b000101
`define FUNC_XORI  6'b000110
`define FUNC_LUI   6'b000111

// ALU opcodes
`define ALU_SHIFT_RIGHT      4'b0000
`define ALU_SHIFT_LEFT       4'b0001
`define ALU_SHIFT_RIGHT_ARIT 4'b0010
`define ALU_PASS             4'b0011
`define ALU_ADD              4'b0100
`define ALU_SUB              4'b0101
`define ALU_AND              4'b0110
`define ALU_OR               4'b0111
`define ALU_XOR              4'b1000
`define ALU_NOR              4'b1001
`define ALU_SLT              4'b1010
`define ALU_CMP              4'b1011
`define ALU_SIGNED_ADD       4'b1100

// AGU opcodes
`define AGU_REG    3'b000                 // Target taken from RS
`define AGU_MEM    3'b001                 // RS plus the offset
`define AGU_BRANCH 3'b010                 // PC+4 plus the shifted offset
`define AGU_JUMP   3'b011                 // PC+4 upper bits with the 26 bit index

// Immediate extension modes
`define EXT_SIGN       2'b00
`define EXT_ZERO_UPPER 2'b01              // Upper half filled with zeros
`define EXT_ZERO_LOWER 2'b10              // Immediate moved into the upper half

`endif

// File: source/mips_decode_pkg.sv
`default_nettype none

`include "mips_decode_defines.svh"

package mips_decode_pkg;

    typedef struct packed {
        logic [`DATA_W-1:0] instr;        // Raw instruction word
        logic [`DATA_W-1:0] pc_plus4;     // Address of the next sequential instruction
    } if_id_t;

    // Field order matches the control unit case table, valid_op sits last
    typedef struct packed {
        logic       pc_modify;            // Jump or branch
        logic       link_ret;             // Return address is written
        logic [1:0] addr_type;            // 00 register, 01 jump index, 10 branch offset
        logic       equal;                // Branch taken on equal
        logic       immediate;            // I-type encoding
        logic       mem_op;               // Load or store
        logic       mem_type;             // 0 load, 1 store
        logic [1:0] mem_size;             // 00 byte, 01 halfword, 11 word
        logic       unsign;               // Zero extended load
        logic       valid_op;             // Low for an unknown opcode
    } class_flags_t;

    typedef struct packed {
        logic       enable;
        logic [1:0] src_a;                // 00 PC+4, 01 RT, 11 extended immediate
        logic       src_b;                // 1 shift amount from SA, 0 register RS
        logic [1:0] dst;                  // 00 RT, 01 RD, 11 register 31
        logic [3:0] opcode;
    } alu_ctrl_t;

    typedef struct packed {
        logic       enable;
        logic       src_addr;             // 1 PC based, 0 register RS based
        logic       dst;                  // 1 new PC, 0 memory address
        logic [2:0] opcode;
    } agu_ctrl_t;

    typedef struct packed {
        alu_ctrl_t  alu;
        agu_ctrl_t  agu;
        logic       jump;
        logic       branch;
        logic       equal;                // BEQ when set, BNE when clear
        logic [1:0] ext_mode;
        logic       mem_op;
        logic       mem_type;
        logic [1:0] mem_size;
        logic       unsign;
        logic       illegal;              // Undefined encoding, every other control is low
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [`DATA_W-1:0] imm;          // Extended immediate
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic [4:0]         rd;
        logic [4:0]         sa;
        logic [`DATA_W-1:0] pc_plus4;
    } id_ex_t;

endpackage

`default_nettype wire

// File: source/pipe_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]     // Payload carried through the stage
) (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_valid,              // One cycle strobe per item
    input  wire payload_t  i_data,
    output logic           o_valid,
    output payload_t       o_data
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            o_valid <= i_valid;
            o_data  <= i_valid ? i_data : '0;   // Empty slots carry no live controls
        end
    end

    // Downstream must see an empty slot right after reset
    a_valid_low_after_reset: assert property (
        @(posedge i_clk) !i_rst_n |=> !o_valid
    ) else $error("pipe_stage_reg: o_valid high in the cycle after reset");

endmodule

`default_nettype wire

// File: source/opcode_classifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_decode_defines.svh"

module opcode_classifier (
    input  wire logic [5:0]                    i_opcode,   // Instruction bits 31:26
    output mips_decode_pkg::class_flags_t      o_flags     // Class flags for the control unit
);

    always_comb begin
        o_flags          = '0;                               // Flags not named below stay low
        o_flags.valid_op = 1'b1;
        case (i_opcode)
            `OP_SPECIAL: begin
                o_flags.immediate = 1'b0;                    // Function code decides the rest
            end
            `OP_J, `OP_JAL: begin
                o_flags.pc_modify = 1'b1;
                o_flags.link_ret  = i_opcode[0];             // JAL differs from J only in bit 0
                o_flags.addr_type = 2'b01;                   // Target built from the 26 bit index
            end
            `OP_BEQ, `OP_BNE: begin
                o_flags.pc_modify = 1'b1;
                o_flags.addr_type = 2'b10;                   // Offset added to PC+4
                o_flags.equal     = ~i_opcode[0];            // BEQ has bit 0 clear
                o_flags.immediate = 1'b1;
            end
            `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                o_flags.immediate = 1'b1;                    // The operation is in opcode bits 2:0
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW: begin
                o_flags.immediate = 1'b1;
                o_flags.mem_op    = 1'b1;
                o_flags.mem_type  = i_opcode[3];             // Stores carry bit 3
                o_flags.mem_size  = i_opcode[1:0];           // Encoding already matches the size field
                o_flags.unsign    = i_opcode[2];             // Only LBU and LHU set bit 2
            end
            default: begin
                o_flags.valid_op  = 1'b0;                    // Control unit turns this into illegal
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_decode_defines.svh"

module control_unit (
    input  wire logic [5:0]                    i_funct,    // R-type funct, or padded opcode bits
    input  wire mips_decode_pkg::class_flags_t i_flags,    // Flags from the opcode classifier
    output mips_decode_pkg::ctrl_t             o_ctrl      // Full control bundle
);

    // Pattern bits run pc_modify, link_ret, addr_type, equal, immediate, mem_op,
    // mem_type, mem_size, unsign and valid_op, as laid out in class_flags_t
    always_comb begin
        o_ctrl = '0;                                                 // Inactive unless a row matches
        casez (i_flags)
            12'b0_?_??_?_0_?_?_??_?_1: begin                          // R-type, JR and JALR
                o_ctrl.alu.enable = 1'b1;
                o_ctrl.alu.src_a  = 2'b01;                           // Operand A is RT
                o_ctrl.alu.dst    = 2'b01;                           // Result goes to RD
                o_ctrl.alu.src_b  = (i_funct[5:2] == 4'b0000);       // SLL, SRL and SRA use SA
                case (i_funct)
                    `FUNC_SLL, `FUNC_SLLV: o_ctrl.alu.opcode = `ALU_SHIFT_LEFT;
                    `FUNC_SRL, `FUNC_SRLV: o_ctrl.alu.opcode = `ALU_SHIFT_RIGHT;
                    `FUNC_SRA, `FUNC_SRAV: o_ctrl.alu.opcode = `ALU_SHIFT_RIGHT_ARIT;
                    `FUNC_ADDU:            o_ctrl.alu.opcode = `ALU_ADD;
                    `FUNC_SUBU:            o_ctrl.alu.opcode = `ALU_SUB;
                    `FUNC_AND:             o_ctrl.alu.opcode = `ALU_AND;
                    `FUNC_OR:              o_ctrl.alu.opcode = `ALU_OR;
                    `FUNC_XOR:             o_ctrl.alu.opcode = `ALU_XOR;
                    `FUNC_NOR:             o_ctrl.alu.opcode = `ALU_NOR;
                    `FUNC_SLT:             o_ctrl.alu.opcode = `ALU_SLT;
                    `FUNC_JR: begin
                        o_ctrl.alu  = '0;                            // Nothing is written back
                        o_ctrl.agu  = '{1'b1, 1'b0, 1'b1, `AGU_REG}; // New PC straight from RS
                        o_ctrl.jump = 1'b1;
                    end
                    `FUNC_JALR: begin
                        o_ctrl.alu.src_a  = 2'b00;                   // PC+4 is the return address
                        o_ctrl.alu.opcode = `ALU_PASS;               // ALU only forwards it to RD
                        o_ctrl.agu        = '{1'b1, 1'b0, 1'b1, `AGU_REG};
                        o_ctrl.jump       = 1'b1;
                    end
                    default: begin
                        o_ctrl         = '0;                         // Unknown function code
                        o_ctrl.illegal = 1'b1;
                    end
                endcase
            end
            12'b0_0_00_0_1_1_?_??_?_1: begin                          // Loads and stores
                o_ctrl.agu      = '{1'b1, 1'b0, 1'b0, `AGU_MEM};     // RS plus offset to memory
                o_ctrl.mem_op   = i_flags.mem_op;
                o_ctrl.mem_type = i_flags.mem_type;
                o_ctrl.mem_size = i_flags.mem_size;
                o_ctrl.unsign   = i_flags.unsign;                    // LW and an unsigned LW match at 32 bits
            end
            12'b0_0_00_0_1_0_0_00_0_1: begin                          // Immediate arithmetic
                o_ctrl.alu.enable = 1'b1;
                o_ctrl.alu.src_a  = 2'b11;                           // Operand A is the extended immediate
                o_ctrl.alu.dst    = 2'b00;                           // Result goes to RT
                case (i_funct)
                    `FUNC_ADDI: o_ctrl.alu.opcode = `ALU_SIGNED_ADD;
                    `FUNC_ANDI: begin
                        o_ctrl.alu.opcode = `ALU_AND;
                        o_ctrl.ext_mode   = `EXT_ZERO_UPPER;         // Logic immediates are zero extended
                    end
                    `FUNC_ORI: begin
                        o_ctrl.alu.opcode = `ALU_OR;
                        o_ctrl.ext_mode   = `EXT_ZERO_UPPER;
                    end
                    `FUNC_XORI: begin
                        o_ctrl.alu.opcode = `ALU_XOR;
                        o_ctrl.ext_mode   = `EXT_ZERO_UPPER;
                    end
                    `FUNC_SLTI: o_ctrl.alu.opcode = `ALU_SLT;
                    `FUNC_LUI: begin
                        o_ctrl.alu.opcode = `ALU_PASS;
                        o_ctrl.ext_mode   = `EXT_ZERO_LOWER;         // Immediate lands in the upper half
                    end
                    default: begin
                        o_ctrl         = '0;
                        o_ctrl.illegal = 1'b1;
                    end
                endcase
            end
            12'b1_0_10_?_1_0_0_00_0_1: begin                          // BEQ and BNE
                o_ctrl.alu    = '{1'b1, 2'b01, 1'b0, 2'b00, `ALU_CMP}; // Compare RT against RS
                o_ctrl.agu    = '{1'b1, 1'b1, 1'b1, `AGU_BRANCH};    // Target from PC+4 and offset
                o_ctrl.branch = 1'b1;                                // Execute decides if it is taken
                o_ctrl.equal  = i_flags.equal;
            end
            12'b1_?_01_0_0_0_0_00_0_1: begin                          // J and JAL
                if (i_flags.link_ret) begin
                    o_ctrl.alu = '{1'b1, 2'b00, 1'b0, 2'b11, `ALU_PASS}; // PC+4 into register 31
                end
                o_ctrl.agu  = '{1'b1, 1'b1, 1'b1, `AGU_JUMP};
                o_ctrl.jump = 1'b1;
            end
            default: begin
                o_ctrl.illegal = 1'b1;                               // Unknown opcode or flag mix
            end
        endcase
    end

    // The branch row and both jump paths come from separate table entries
    always_comb begin
        assert (!(o_ctrl.jump && o_ctrl.branch))
            else $error("control_unit: jump and branch both set, funct %h", i_funct);
    end

endmodule

`default_nettype wire

// File: source/imm_extender.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_decode_defines.svh"

module imm_extender (
    input  wire logic [15:0]          i_imm,    // Instruction bits 15:0
    input  wire logic [1:0]           i_mode,   // Extension mode from the control unit
    output logic      [`DATA_W-1:0]   o_imm     // Extended immediate
);

    always_comb begin
        case (i_mode)
            `EXT_SIGN:       o_imm = {{(`DATA_W-16){i_imm[15]}}, i_imm}; // Replicate bit 15
            `EXT_ZERO_UPPER: o_imm = {{(`DATA_W-16){1'b0}}, i_imm};
            `EXT_ZERO_LOWER: o_imm = {i_imm, {(`DATA_W-16){1'b0}}};      // LUI form
            default:         o_imm = '0;
        endcase
    end

    // The control unit only ever issues the three defined modes
    always_comb begin
        assert (i_mode != 2'b11)
            else $error("imm_extender: undefined extension mode %b", i_mode);
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_decode_defines.svh"

module decode_stage (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_instr_valid,   // Instruction strobe from fetch
    input  wire logic [`DATA_W-1:0]    i_instr,
    input  wire logic [`DATA_W-1:0]    i_pc_plus4,
    output logic                       o_ex_valid,      // Two cycles after i_instr_valid
    output mips_decode_pkg::id_ex_t    o_ex             // Decoded bundle for execute
);

    mips_decode_pkg::if_id_t       if_id_d;             // Fetch side of IF/ID
    mips_decode_pkg::if_id_t       if_id_q;             // Instruction being decoded
    logic                          if_id_valid;
    mips_decode_pkg::class_flags_t flags;
    mips_decode_pkg::ctrl_t        ctrl;
    logic [5:0]                    funct;
    logic [`DATA_W-1:0]            imm_ext;
    mips_decode_pkg::id_ex_t       id_ex_d;             // Decode side of ID/EX

    assign if_id_d.instr    = i_instr;
    assign if_id_d.pc_plus4 = i_pc_plus4;

    pipe_stage_reg #(.payload_t(mips_decode_pkg::if_id_t)) u_if_id (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_instr_valid),
        .i_data  (if_id_d),
        .o_valid (if_id_valid),
        .o_data  (if_id_q)
    );

    opcode_classifier u_classifier (
        .i_opcode (if_id_q.instr[31:26]),
        .o_flags  (flags)
    );

    // I-type arithmetic is selected by the low opcode bits, R-type by bits 5:0
    assign funct = flags.immediate ? {3'b000, if_id_q.instr[28:26]} : if_id_q.instr[5:0];

    control_unit u_control (
        .i_funct (funct),
        .i_flags (flags),
        .o_ctrl  (ctrl)
    );

    imm_extender u_imm_ext (
        .i_imm  (if_id_q.instr[15:0]),
        .i_mode (ctrl.ext_mode),
        .o_imm  (imm_ext)
    );

    assign id_ex_d.ctrl     = ctrl;
    assign id_ex_d.imm      = imm_ext;
    assign id_ex_d.rs       = if_id_q.instr[25:21];
    assign id_ex_d.rt       = if_id_q.instr[20:16];
    assign id_ex_d.rd       = if_id_q.instr[15:11];
    assign id_ex_d.sa       = if_id_q.instr[10:6];
    assign id_ex_d.pc_plus4 = if_id_q.pc_plus4;         // J target rebuilds from rs, rt and imm

    pipe_stage_reg #(.payload_t(mips_decode_pkg::id_ex_t)) u_id_ex (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (if_id_valid),
        .i_data  (id_ex_d),
        .o_valid (o_ex_valid),
        .o_data  (o_ex)
    );

endmodule

`default_nettype wire

// File: tb/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic [5:0]                 opcode;   // Primary opcode of the template
    logic [5:0]                 funct;    // Kept for SPECIAL only, every other field is random
    logic [1:0]                 gap;      // Idle slots issued ahead of the entry
    mips_decode_pkg::alu_ctrl_t alu;      // Expected ALU controls
    mips_decode_pkg::agu_ctrl_t agu;      // Expected AGU controls
    logic [10:0]                rest;     // Jump down to illegal, in ctrl_t order
} vector_t;

// Tail of ctrl_t after the AGU field is jump, branch, equal, ext_mode, mem_op, mem_type,
// mem_size, unsign and illegal
localparam logic [10:0] NONE      = 11'b0_0_0_00_0_0_00_0_0;
localparam logic [10:0] JUMP      = 11'b1_0_0_00_0_0_00_0_0;
localparam logic [10:0] BRANCH    = 11'b0_1_0_00_0_0_00_0_0;
localparam logic [10:0] EQUAL     = 11'b0_0_1_00_0_0_00_0_0;  // BEQ only
localparam logic [10:0] EXT_UPPER = {3'b000, `EXT_ZERO_UPPER, 6'b00_0000};  // ANDI, ORI and XORI
localparam logic [10:0] EXT_LOWER = {3'b000, `EXT_ZERO_LOWER, 6'b00_0000};
localparam logic [10:0] MEM       = 11'b0_0_0_00_1_0_00_0_0;
localparam logic [10:0] STORE     = 11'b0_0_0_00_0_1_00_0_0;
localparam logic [10:0] SIZE_H    = 11'b0_0_0_00_0_0_01_0_0;
localparam logic [10:0] SIZE_W    = 11'b0_0_0_00_0_0_11_0_0;  // Byte is the zero size
localparam logic [10:0] UNSIGN    = 11'b0_0_0_00_0_0_00_1_0;
localparam logic [10:0] ILLEGAL   = 11'b0_0_0_00_0_0_00_0_1;

// AGU column is {enable, src_addr, dst} then the AGU opcode
localparam mips_decode_pkg::agu_ctrl_t AG_OFF = 6'b000_000;
localparam mips_decode_pkg::agu_ctrl_t AG_RS  = {3'b101, `AGU_REG};     // New PC from RS
localparam mips_decode_pkg::agu_ctrl_t AG_MEM = {3'b100, `AGU_MEM};     // RS plus offset
localparam mips_decode_pkg::agu_ctrl_t AG_BR  = {3'b111, `AGU_BRANCH};
localparam mips_decode_pkg::agu_ctrl_t AG_J   = {3'b111, `AGU_JUMP};

localparam int NUM_VECTORS = 37;

// ALU column is {enable, src_a, src_b, dst} then the ALU opcode
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{`OP_SPECIAL, `FUNC_SLL,  2'd0, {6'b1_01_1_01, `ALU_SHIFT_LEFT},       AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SRL,  2'd1, {6'b1_01_1_01, `ALU_SHIFT_RIGHT},      AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SRA,  2'd0, {6'b1_01_1_01, `ALU_SHIFT_RIGHT_ARIT}, AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SLLV, 2'd0, {6'b1_01_0_01, `ALU_SHIFT_LEFT},       AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SRLV, 2'd2, {6'b1_01_0_01, `ALU_SHIFT_RIGHT},      AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SRAV, 2'd0, {6'b1_01_0_01, `ALU_SHIFT_RIGHT_ARIT}, AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_ADDU, 2'd0, {6'b1_01_0_01, `ALU_ADD},              AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SUBU, 2'd1, {6'b1_01_0_01, `ALU_SUB},              AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_AND,  2'd0, {6'b1_01_0_01, `ALU_AND},              AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_OR,   2'd0, {6'b1_01_0_01, `ALU_OR},               AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_XOR,  2'd3, {6'b1_01_0_01, `ALU_XOR},              AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_NOR,  2'd0, {6'b1_01_0_01, `ALU_NOR},              AG_OFF, NONE},
    '{`OP_SPECIAL, `FUNC_SLT,  2'd0, {6'b1_01_0_01, `ALU_SLT},              AG_OFF, NONE},
    '{`OP_SPECIAL, 6'b111111,  2'd1, 10'b0,                                 AG_OFF, ILLEGAL},
    '{`OP_SPECIAL, 6'b000001,  2'd0, 10'b0,                                 AG_OFF, ILLEGAL},
    '{`OP_SPECIAL, `FUNC_JR,   2'd0, 10'b0,                                 AG_RS,  JUMP},
    '{`OP_SPECIAL, `FUNC_JALR, 2'd1, {6'b1_00_0_01, `ALU_PASS},             AG_RS,  JUMP},
    '{`OP_J,       6'b000000,  2'd0, 10'b0,                                 AG_J,   JUMP},
    '{`OP_JAL,     6'b000000,  2'd0, {6'b1_00_0_11, `ALU_PASS},             AG_J,   JUMP},
    '{`OP_BEQ,     6'b000000,  2'd2, {6'b1_01_0_00, `ALU_CMP},              AG_BR,  BRANCH | EQUAL},
    '{`OP_BNE,     6'b000000,  2'd0, {6'b1_01_0_00, `ALU_CMP},              AG_BR,  BRANCH},
    '{`OP_ADDI,    6'b000000,  2'd0, {6'b1_11_0_00, `ALU_SIGNED_ADD},       AG_OFF, NONE},
    '{`OP_SLTI,    6'b000000,  2'd0, {6'b1_11_0_00, `ALU_SLT},              AG_OFF, NONE},
    '{`OP_ANDI,    6'b000000,  2'd1, {6'b1_11_0_00, `ALU_AND},              AG_OFF, EXT_UPPER},
    '{`OP_ORI,     6'b000000,  2'd0, {6'b1_11_0_00, `ALU_OR},               AG_OFF, EXT_UPPER},
    '{`OP_XORI,    6'b000000,  2'd0, {6'b1_11_0_00, `ALU_XOR},              AG_OFF, EXT_UPPER},
    '{`OP_LUI,     6'b000000,  2'd3, {6'b1_11_0_00, `ALU_PASS},             AG_OFF, EXT_LOWER},
    '{`OP_LB,      6'b000000,  2'd0, 10'b0,                                 AG_MEM, MEM},
    '{`OP_LH,      6'b000000,  2'd0, 10'b0,                                 AG_MEM, MEM | SIZE_H},
    '{`OP_LW,      6'b000000,  2'd1, 10'b0,                                 AG_MEM, MEM | SIZE_W},
    '{`OP_LBU,     6'b000000,  2'd0, 10'b0,                                 AG_MEM, MEM | UNSIGN},
    '{`OP_LHU,     6'b000000,  2'd0, 10'b0,                          AG_MEM, MEM | SIZE_H | UNSIGN},
    '{`OP_SB,      6'b000000,  2'd2, 10'b0,                                 AG_MEM, MEM | STORE},
    '{`OP_SH,      6'b000000,  2'd0, 10'b0,                           AG_MEM, MEM | STORE | SIZE_H},
    '{`OP_SW,      6'b000000,  2'd0, 10'b0,                           AG_MEM, MEM | STORE | SIZE_W},
    '{6'b111111,   6'b000000,  2'd0, 10'b0,                                 AG_OFF, ILLEGAL},
    '{6'b000001,   6'b000000,  2'd1, 10'b0,                                 AG_OFF, ILLEGAL}
};

`endif

// File: tb/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_decode_defines.svh"

module tb_decode_stage;

    `include "decode_vectors.svh"

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = RESET_CYCLES + 4 * NUM_VECTORS + 10;  // Entry plus up to 3 idle slots
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;                  // x^32 + x^22 + x^2 + x + 1

    typedef struct packed {
        logic                    valid;
        mips_decode_pkg::id_ex_t ex;
    } slot_t;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic [`DATA_W-1:0]      instr;
    logic [`DATA_W-1:0]      pc_plus4;
    logic                    ex_valid;
    mips_decode_pkg::id_ex_t ex;
    logic [31:0]             lfsr = 32'h78d78cc5;
    int                      cycles = 0;
    int                      slot = 0;                 // Issue slot count, shown in error lines
    slot_t                   expect_q [$];             // One entry per slot, two slots ahead of o_ex

    decode_stage i_decode_stage (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_pc_plus4    (pc_plus4),
        .o_ex_valid    (ex_valid),
        .o_ex          (ex)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                        // 40 ns period
    end

    // Galois LFSR, one step per bit taken, newest bit lands in bit 0
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return bits;
    endfunction

    function automatic logic [`DATA_W-1:0] extend_imm(input logic [1:0] mode, input logic [15:0] imm);
        case (mode)
            `EXT_SIGN:       return {{16{imm[15]}}, imm};   // Bit 15 copied into the upper half
            `EXT_ZERO_UPPER: return {16'h0000, imm};
            `EXT_ZERO_LOWER: return {imm, 16'h0000};        // LUI places it in the upper half
            default:         return '0;
        endcase
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] slot %0d o_ex_valid got %h expected %h", slot, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input mips_decode_pkg::ctrl_t got, input mips_decode_pkg::ctrl_t exp);
        if (got !== exp) begin
            $display("[FAIL] slot %0d o_ex.ctrl got %h expected %h", slot, got, exp);
            abort_run();
        end
    endtask

    task automatic check_imm(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] slot %0d o_ex.imm got %h expected %h", slot, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ex(input mips_decode_pkg::id_ex_t got, input mips_decode_pkg::id_ex_t exp);
        if (got !== exp) begin
            $display("[FAIL] slot %0d o_ex got %h expected %h", slot, got, exp);
            abort_run();
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge both checks and drives
    task automatic step(input logic valid, input logic [31:0] word, input logic [31:0] pc,
                        input slot_t exp_next);
        slot_t exp;
        @(negedge clk);
        exp = expect_q.pop_front();
        check_valid(ex_valid, exp.valid);
        check_ctrl(ex.ctrl, exp.ex.ctrl);
        check_imm(ex.imm, exp.ex.imm);
        check_ex(ex, exp.ex);                          // Register fields and PC+4
        instr_valid = valid;
        instr       = word;
        pc_plus4    = pc;
        expect_q.push_back(exp_next);
        slot++;
    endtask

    // Garbage on the bus while valid is low must not reach o_ex
    task automatic issue_idle();
        logic [31:0] word;
        logic [31:0] pc;
        word = take_bits(32);
        pc   = take_bits(32);
        step(1'b0, word, pc, '0);
    endtask

    task automatic issue_vector(input vector_t v);
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] pc;
        slot_t       exp;
        rnd  = take_bits(26);
        word = {v.opcode, rnd[25:0]};                  // Register and immediate fields are random
        if (v.opcode == `OP_SPECIAL) begin
            word[5:0] = v.funct;                       // R-type keeps its function code
        end
        rnd = take_bits(30);
        pc  = {rnd[29:0], 2'b00};                      // Word aligned PC+4
        exp.valid       = 1'b1;
        exp.ex.ctrl     = {v.alu, v.agu, v.rest};
        exp.ex.imm      = extend_imm(exp.ex.ctrl.ext_mode, word[15:0]);
        exp.ex.rs       = word[25:21];
        exp.ex.rt       = word[20:16];
        exp.ex.rd       = word[15:11];
        exp.ex.sa       = word[10:6];
        exp.ex.pc_plus4 = pc;
        step(1'b1, word, pc, exp);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc_plus4    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_valid(ex_valid, 1'b0);                   // Both stages cleared by reset
        check_ex(ex, '0);
        rst_n = 1'b1;
        expect_q.push_back('0);                        // IF/ID and ID/EX start out empty
        expect_q.push_back('0);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            repeat (VECTORS[i].gap) issue_idle();
            issue_vector(VECTORS[i]);
        end
        issue_idle();                                  // Two more slots drain the pipeline
        issue_idle();
        $display(">>> PASS");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout, the run did not end within %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.f
+incdir+source
+incdir+tb
source/mips_decode_pkg.sv
source/pipe_stage_reg.sv
source/opcode_classifier.sv
source/control_unit.sv
source/imm_extender.sv
source/decode_stage.sv
tb/tb_decode_stage.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --timescale 1ns/10ps \
		--top-module tb_decode_stage -f decode_stage.f \
		-Mdir obj_dir -o sim_decode_stage
	./obj_dir/sim_decode_stage

clean:
	rm -rf obj_dir
